//--- exec_consts.svh
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// data path and address width
`define XLEN 32

// architectural register index width
`define REG_IDX_W 5

// completion buffer index, 8 entries
`define CB_IDX_W 3

// multiplier latency in clock edges
`define MUL_STAGES 3

// link value step for jumps
`define PC_STEP 4

// low target bits that must be zero for an aligned fetch
`define ALIGN_MASK 2'b11

`endif

//--- exec_pkg.sv
`include "exec_consts.svh"

package exec_pkg;

  // operation codes seen by the execute stage
  // codes 12 to 15 are not defined and count as illegal
  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_SLT  = 4'd5,
    OP_BEQ  = 4'd6,
    OP_BNE  = 4'd7,
    OP_BLT  = 4'd8,
    OP_JAL  = 4'd9,
    OP_JALR = 4'd10,
    OP_MUL  = 4'd11
  } fu_op_t;

  // exception type reported with each completion buffer writeback
  typedef enum logic [1:0] {
    EXC_NONE       = 2'd0,
    EXC_ILLEGAL    = 2'd1,
    EXC_MAL_TARGET = 2'd2
  } exc_t;

  // one data word or address
  typedef logic [`XLEN-1:0] word_t;

  // destination register index
  typedef logic [`REG_IDX_W-1:0] reg_idx_t;

  // completion buffer slot
  typedef logic [`CB_IDX_W-1:0] cb_idx_t;

endpackage

//--- alu_unit.sv
`timescale 1ns/100ps
`include "exec_consts.svh"

module alu_unit (
  input  exec_pkg::fu_op_t op,
  input  exec_pkg::word_t  rs1_data,
  input  exec_pkg::word_t  rs2_data,
  input  exec_pkg::word_t  pc,
  output exec_pkg::word_t  alu_result
);

  exec_pkg::word_t sum;
  exec_pkg::word_t diff;
  exec_pkg::word_t link;
  logic            less_signed;

  // adder and subtractor wrap at XLEN
  assign sum  = rs1_data + rs2_data;
  assign diff = rs1_data - rs2_data;

  // return address for jal and jalr
  assign link = pc + `PC_STEP;

  assign less_signed = $signed(rs1_data) < $signed(rs2_data);

  always_comb begin
    case (op)
      exec_pkg::OP_ADD: begin
        alu_result = sum;
      end
      exec_pkg::OP_SUB: begin
        alu_result = diff;
      end
      exec_pkg::OP_AND: begin
        alu_result = rs1_data & rs2_data;
      end
      exec_pkg::OP_OR: begin
        alu_result = rs1_data | rs2_data;
      end
      exec_pkg::OP_XOR: begin
        alu_result = rs1_data ^ rs2_data;
      end
      exec_pkg::OP_SLT: begin
        // zero extend the compare flag
        alu_result = {{(`XLEN-1){1'b0}}, less_signed};
      end
      exec_pkg::OP_JAL,
      exec_pkg::OP_JALR: begin
        alu_result = link;
      end
      default: begin
        // branches, multiply and illegal codes carry no alu data
        alu_result = '0;
      end
    endcase
  end

endmodule

//--- branch_resolve.sv
`timescale 1ns/100ps
`include "exec_consts.svh"

module branch_resolve (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             issue_valid,
  input  exec_pkg::fu_op_t op,
  input  exec_pkg::word_t  rs1_data,
  input  exec_pkg::word_t  rs2_data,
  input  exec_pkg::word_t  imm,
  input  exec_pkg::word_t  pc,
  input  logic             prediction,
  output logic             mal_target,
  output logic             redirect,
  output exec_pkg::word_t  redirect_addr,
  output logic             redirect_ff
);

  logic            is_branch;
  logic            is_jump;
  logic            taken;
  logic            mispredict;
  exec_pkg::word_t pc_next;
  exec_pkg::word_t pc_target;
  exec_pkg::word_t jalr_target;
  exec_pkg::word_t jump_target;
  exec_pkg::word_t check_target;

  assign is_branch = (op == exec_pkg::OP_BEQ) || (op == exec_pkg::OP_BNE) ||
                     (op == exec_pkg::OP_BLT);
  assign is_jump   = (op == exec_pkg::OP_JAL) || (op == exec_pkg::OP_JALR);

  // branch condition
  always_comb begin
    case (op)
      exec_pkg::OP_BEQ: taken = (rs1_data == rs2_data);
      exec_pkg::OP_BNE: taken = (rs1_data != rs2_data);
      exec_pkg::OP_BLT: taken = ($signed(rs1_data) < $signed(rs2_data));
      default:          taken = 1'b0;
    endcase
  end

  // pc relative target serves both branches and jal
  assign pc_target   = pc + imm;
  assign pc_next     = pc + `PC_STEP;
  assign jalr_target = (rs1_data + imm) & ~exec_pkg::word_t'(1);
  assign jump_target = (op == exec_pkg::OP_JALR) ? jalr_target : pc_target;

  // a target with either low bit set cannot be fetched
  assign check_target = is_jump ? jump_target : pc_target;
  assign mal_target   = issue_valid && (is_branch || is_jump) &&
                        (|(check_target[1:0] & `ALIGN_MASK));

  assign mispredict = is_branch && (prediction ^ taken);

  // jumps always redirect, branches only on a wrong guess
  assign redirect = issue_valid && !mal_target && (is_jump || mispredict);

  always_comb begin
    if (is_jump) begin
      redirect_addr = jump_target;
    end else if (taken) begin
      redirect_addr = pc_target;
    end else begin
      redirect_addr = pc_next;
    end
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      redirect_ff <= 1'b0;
    end else begin
      redirect_ff <= redirect;
    end
  end

  // a faulting target must never steer fetch
  redirect_aligned: assert property (
    @(posedge CLK) disable iff (!nRST)
      redirect |-> ((redirect_addr[1:0] & `ALIGN_MASK) == 2'b00)
  );

endmodule

//--- mul_pipe.sv
`timescale 1ns/100ps
`include "exec_consts.svh"

module mul_pipe (
  input  logic               CLK,
  input  logic               nRST,
  input  logic               issue_valid,
  input  exec_pkg::fu_op_t   op,
  input  exec_pkg::word_t    rs1_data,
  input  exec_pkg::word_t    rs2_data,
  input  exec_pkg::reg_idx_t rd,
  input  exec_pkg::cb_idx_t  cb_index,
  output logic               mul_valid,
  output exec_pkg::word_t    mul_result,
  output exec_pkg::reg_idx_t mul_rd,
  output exec_pkg::cb_idx_t  mul_index
);

  localparam int HALF = `XLEN / 2;

  logic                  start;
  logic                  vld     [`MUL_STAGES];
  exec_pkg::reg_idx_t    rd_q    [`MUL_STAGES];
  exec_pkg::cb_idx_t     index_q [`MUL_STAGES];

  // stage 1 operands, stage 2 partial products, stage 3 product
  exec_pkg::word_t       op_a;
  exec_pkg::word_t       op_b;
  exec_pkg::word_t       pp_low;
  logic [HALF-1:0]       pp_cross;
  exec_pkg::word_t       product;

  assign start = issue_valid && (op == exec_pkg::OP_MUL);

  // valid bits step once per clock so back to back issues stay apart
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < `MUL_STAGES; i++) begin
        vld[i] <= 1'b0;
      end
    end else begin
      vld[0] <= start;
      for (int i = 1; i < `MUL_STAGES; i++) begin
        vld[i] <= vld[i-1];
      end
    end
  end

  // tag and data ride alongside the valid bits
  always_ff @(posedge CLK) begin
    rd_q[0]    <= rd;
    index_q[0] <= cb_index;
    for (int i = 1; i < `MUL_STAGES; i++) begin
      rd_q[i]    <= rd_q[i-1];
      index_q[i] <= index_q[i-1];
    end
    op_a     <= rs1_data;
    op_b     <= rs2_data;
    // only the low cross term bits reach the low product word
    pp_low   <= op_a[HALF-1:0] * op_b[HALF-1:0];
    pp_cross <= op_a[HALF-1:0] * op_b[`XLEN-1:HALF] + op_a[`XLEN-1:HALF] * op_b[HALF-1:0];
    product  <= pp_low + {pp_cross, {HALF{1'b0}}};
  end

  assign mul_valid  = vld[`MUL_STAGES-1];
  assign mul_result = product;
  assign mul_rd     = rd_q[`MUL_STAGES-1];
  assign mul_index  = index_q[`MUL_STAGES-1];

  mul_valid_known: assert property (
    @(posedge CLK) disable iff (!nRST) !$isunknown(mul_valid)
  );

endmodule

//--- wb_arbiter.sv
`timescale 1ns/100ps
`include "exec_consts.svh"

module wb_arbiter (
  input  logic               issue_valid,
  input  exec_pkg::fu_op_t   op,
  input  exec_pkg::word_t    pc,
  input  exec_pkg::word_t    alu_result,
  input  exec_pkg::reg_idx_t rd,
  input  exec_pkg::cb_idx_t  cb_index,
  input  logic               mal_target,
  input  logic               mul_valid,
  input  exec_pkg::word_t    mul_result,
  input  exec_pkg::reg_idx_t mul_rd,
  input  exec_pkg::cb_idx_t  mul_index,
  output logic               wb_valid,
  output exec_pkg::cb_idx_t  wb_index,
  output exec_pkg::reg_idx_t wb_rd,
  output exec_pkg::word_t    wb_data,
  output logic               wb_wen,
  output exec_pkg::exc_t     wb_exc
);

  logic           single;
  logic           legal;
  logic           is_branch;
  exec_pkg::exc_t single_exc;

  // everything but a multiply finishes in the issue cycle
  assign single = issue_valid && (op != exec_pkg::OP_MUL);

  always_comb begin
    case (op)
      exec_pkg::OP_ADD, exec_pkg::OP_SUB, exec_pkg::OP_AND,
      exec_pkg::OP_OR, exec_pkg::OP_XOR, exec_pkg::OP_SLT,
      exec_pkg::OP_BEQ, exec_pkg::OP_BNE, exec_pkg::OP_BLT,
      exec_pkg::OP_JAL, exec_pkg::OP_JALR, exec_pkg::OP_MUL: legal = 1'b1;
      default:                                               legal = 1'b0;
    endcase
  end

  assign is_branch = (op == exec_pkg::OP_BEQ) || (op == exec_pkg::OP_BNE) ||
                     (op == exec_pkg::OP_BLT);

  // illegal code outranks a bad target
  assign single_exc = !legal     ? exec_pkg::EXC_ILLEGAL    :
                      mal_target ? exec_pkg::EXC_MAL_TARGET :
                                   exec_pkg::EXC_NONE;

  always_comb begin
    if (single) begin
      wb_valid = 1'b1;
      wb_index = cb_index;
      wb_rd    = rd;
      wb_exc   = single_exc;
      // faulting pc goes to the completion buffer in place of data
      wb_data  = (single_exc == exec_pkg::EXC_NONE) ? alu_result : pc;
      wb_wen   = (single_exc == exec_pkg::EXC_NONE) && !is_branch;
    end else if (mul_valid) begin
      wb_valid = 1'b1;
      wb_index = mul_index;
      wb_rd    = mul_rd;
      wb_exc   = exec_pkg::EXC_NONE;
      wb_data  = mul_result;
      wb_wen   = 1'b1;
    end else begin
      wb_valid = 1'b0;
      wb_index = '0;
      wb_rd    = '0;
      wb_exc   = exec_pkg::EXC_NONE;
      wb_data  = '0;
      wb_wen   = 1'b0;
    end
  end

  // issue side must keep single-cycle ops off a multiply completion slot
  always_comb begin
    if (!$isunknown({issue_valid, mul_valid})) begin
      no_wb_collision: assert final (!(single && mul_valid));
    end
  end

endmodule

//--- exec_stage.sv
`timescale 1ns/100ps
`include "exec_consts.svh"

module exec_stage (
  input  logic               CLK,
  input  logic               nRST,
  // issue group
  input  logic               issue_valid,
  input  exec_pkg::fu_op_t   op,
  input  exec_pkg::word_t    rs1_data,
  input  exec_pkg::word_t    rs2_data,
  input  exec_pkg::word_t    imm,
  input  exec_pkg::word_t    pc,
  input  exec_pkg::reg_idx_t rd,
  input  exec_pkg::cb_idx_t  cb_index,
  input  logic               prediction,
  // redirect to fetch
  output logic               redirect,
  output exec_pkg::word_t    redirect_addr,
  output logic               redirect_ff,
  // completion buffer writeback
  output logic               wb_valid,
  output exec_pkg::cb_idx_t  wb_index,
  output exec_pkg::reg_idx_t wb_rd,
  output exec_pkg::word_t    wb_data,
  output logic               wb_wen,
  output exec_pkg::exc_t     wb_exc
);

  exec_pkg::word_t    alu_result;
  logic               mal_target;
  logic               mul_valid;
  exec_pkg::word_t    mul_result;
  exec_pkg::reg_idx_t mul_rd;
  exec_pkg::cb_idx_t  mul_index;

  alu_unit u_alu (
    .op         (op),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .pc         (pc),
    .alu_result (alu_result)
  );

  branch_resolve u_branch (
    .CLK           (CLK),
    .nRST          (nRST),
    .issue_valid   (issue_valid),
    .op            (op),
    .rs1_data      (rs1_data),
    .rs2_data      (rs2_data),
    .imm           (imm),
    .pc            (pc),
    .prediction    (prediction),
    .mal_target    (mal_target),
    .redirect      (redirect),
    .redirect_addr (redirect_addr),
    .redirect_ff   (redirect_ff)
  );

  mul_pipe u_mul (
    .CLK         (CLK),
    .nRST        (nRST),
    .issue_valid (issue_valid),
    .op          (op),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .rd          (rd),
    .cb_index    (cb_index),
    .mul_valid   (mul_valid),
    .mul_result  (mul_result),
    .mul_rd      (mul_rd),
    .mul_index   (mul_index)
  );

  // single-cycle path wins over the multiplier
  wb_arbiter u_wb (
    .issue_valid (issue_valid),
    .op          (op),
    .pc          (pc),
    .alu_result  (alu_result),
    .rd          (rd),
    .cb_index    (cb_index),
    .mal_target  (mal_target),
    .mul_valid   (mul_valid),
    .mul_result  (mul_result),
    .mul_rd      (mul_rd),
    .mul_index   (mul_index),
    .wb_valid    (wb_valid),
    .wb_index    (wb_index),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .wb_wen      (wb_wen),
    .wb_exc      (wb_exc)
  );

endmodule

//--- tb_exec_stage.sv
`timescale 1ns/100ps
`include "exec_consts.svh"

module tb_exec_stage;

  localparam int CLK_PERIOD = 100;
  localparam int MAX_REC    = 64;
  localparam int FIELDS     = 17;

  // trace column positions
  localparam int F_VALID = 0;
  localparam int F_OP    = 1;
  localparam int F_RS1   = 2;
  localparam int F_RS2   = 3;
  localparam int F_IMM   = 4;
  localparam int F_PC    = 5;
  localparam int F_RD    = 6;
  localparam int F_IDX   = 7;
  localparam int F_PRED  = 8;
  localparam int F_OFF   = 9;
  localparam int F_EIDX  = 10;
  localparam int F_ERD   = 11;
  localparam int F_EDATA = 12;
  localparam int F_EWEN  = 13;
  localparam int F_EEXC  = 14;
  localparam int F_REDIR = 15;
  localparam int F_RADDR = 16;

  logic               CLK;
  logic               nRST;
  logic               issue_valid;
  exec_pkg::fu_op_t   op;
  exec_pkg::word_t    rs1_data;
  exec_pkg::word_t    rs2_data;
  exec_pkg::word_t    imm;
  exec_pkg::word_t    pc;
  exec_pkg::reg_idx_t rd;
  exec_pkg::cb_idx_t  cb_index;
  logic               prediction;
  logic               redirect;
  exec_pkg::word_t    redirect_addr;
  logic               redirect_ff;
  logic               wb_valid;
  exec_pkg::cb_idx_t  wb_index;
  exec_pkg::reg_idx_t wb_rd;
  exec_pkg::word_t    wb_data;
  logic               wb_wen;
  exec_pkg::exc_t     wb_exc;

  logic [31:0] trace [MAX_REC][FIELDS];
  int          n_rec;
  bit          trace_loaded;
  int          errors;
  int          n_pass;
  int          n_fail;
  int          pend [$];
  int          rec_due [MAX_REC];
  int          rec_fin [MAX_REC];
  bit          rec_bad [MAX_REC];
  logic        prev_redir;

  exec_stage DUT (.*);

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  task automatic load_trace();
    int          fd;
    int          code;
    string       line;
    logic [31:0] v [FIELDS];
    n_rec = 0;
    fd = $fopen("exec_trace.txt", "r");
    while (fd != 0 && !$feof(fd)) begin
      line = "";
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
        code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                       v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8],
                       v[9], v[10], v[11], v[12], v[13], v[14], v[15], v[16]);
        if (code == FIELDS && n_rec < MAX_REC) begin
          for (int k = 0; k < FIELDS; k++) begin
            trace[n_rec][k] = v[k];
          end
          n_rec++;
        end else begin
          $display("trace line not understood: %s", line);
          errors++;
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
  endtask

  task automatic drive_issue(input int i);
    issue_valid <= 1'b1;
    op          <= exec_pkg::fu_op_t'(trace[i][F_OP][3:0]);
    rs1_data    <= trace[i][F_RS1];
    rs2_data    <= trace[i][F_RS2];
    imm         <= trace[i][F_IMM];
    pc          <= trace[i][F_PC];
    rd          <= trace[i][F_RD][`REG_IDX_W-1:0];
    cb_index    <= trace[i][F_IDX][`CB_IDX_W-1:0];
    prediction  <= trace[i][F_PRED][0];
  endtask

  // idle cycles carry noise on everything but the strobe
  task automatic drive_idle();
    issue_valid <= 1'b0;
    op          <= exec_pkg::fu_op_t'(4'($urandom));
    rs1_data    <= $urandom;
    rs2_data    <= $urandom;
    imm         <= $urandom;
    pc          <= $urandom;
    rd          <= exec_pkg::reg_idx_t'($urandom);
    cb_index    <= exec_pkg::cb_idx_t'($urandom);
    prediction  <= 1'($urandom);
  endtask

  task automatic flag_mismatch(input int id, input string name, input logic [31:0] got,
                               input logic [31:0] want);
    $display("Mismatch %s: got 0x%h expected 0x%h (record %0d)", name, got, want, id);
    errors++;
    if (id >= 0) begin
      rec_bad[id] = 1'b1;
    end
  endtask

  task automatic compare_writeback(input int id, input int c);
    logic data_used;
    // data is only meaningful when written or when it carries the faulting pc
    data_used = trace[id][F_EWEN][0] || (trace[id][F_EEXC][1:0] != 2'd0);
    if (wb_valid !== 1'b1) begin
      $display("record %0d: no writeback seen in cycle %0d", id, c);
      errors++;
      rec_bad[id] = 1'b1;
    end else begin
      if (wb_index !== trace[id][F_EIDX][`CB_IDX_W-1:0]) begin
        flag_mismatch(id, "wb_index", wb_index, trace[id][F_EIDX]);
      end
      if (wb_rd !== trace[id][F_ERD][`REG_IDX_W-1:0]) begin
        flag_mismatch(id, "wb_rd", wb_rd, trace[id][F_ERD]);
      end
      if (data_used && wb_data !== trace[id][F_EDATA]) begin
        flag_mismatch(id, "wb_data", wb_data, trace[id][F_EDATA]);
      end
      if (wb_wen !== trace[id][F_EWEN][0]) begin
        flag_mismatch(id, "wb_wen", wb_wen, trace[id][F_EWEN]);
      end
      if (wb_exc !== trace[id][F_EEXC][1:0]) begin
        flag_mismatch(id, "wb_exc", wb_exc, trace[id][F_EEXC]);
      end
    end
  endtask

  task automatic scoreboard_cycle(input int c);
    int   id;
    int   slot;
    int   hits;
    int   owner;
    int   owner_prev;
    logic want_redir;
    id   = -1;
    slot = -1;
    hits = 0;
    foreach (pend[k]) begin
      if (rec_due[pend[k]] == c) begin
        hits++;
        if (id < 0) begin
          id   = pend[k];
          slot = k;
        end
      end
    end
    if (hits > 1) begin
      $display("cycle %0d: trace schedules %0d results at once", c, hits);
      errors++;
    end
    if (id >= 0) begin
      pend.delete(slot);
      compare_writeback(id, c);
    end else if (wb_valid !== 1'b0) begin
      $display("cycle %0d: writeback seen with no result due", c);
      errors++;
    end
    // redirect belongs to this cycle's issue, redirect_ff to the previous one
    owner      = (c < n_rec && trace[c][F_VALID][0]) ? c : -1;
    owner_prev = (c > 0 && c - 1 < n_rec && trace[c-1][F_VALID][0]) ? c - 1 : -1;
    want_redir = (owner >= 0) ? trace[c][F_REDIR][0] : 1'b0;
    if (redirect !== want_redir) begin
      flag_mismatch(owner, "redirect", redirect, want_redir);
    end else if (want_redir && redirect_addr !== trace[c][F_RADDR]) begin
      flag_mismatch(owner, "redirect_addr", redirect_addr, trace[c][F_RADDR]);
    end
    if (redirect_ff !== prev_redir) begin
      flag_mismatch(owner_prev, "redirect_ff", redirect_ff, prev_redir);
    end
    prev_redir = want_redir;
  endtask

  task automatic close_records(input int c);
    // only records already issued have a finish cycle
    for (int i = 0; i < n_rec; i++) begin
      if (i <= c && trace[i][F_VALID][0] && rec_fin[i] == c) begin
        if (rec_bad[i]) begin
          n_fail++;
          $display("test %0d (op %h): failed", i, trace[i][F_OP][3:0]);
        end else begin
          n_pass++;
          $display("test %0d (op %h): passed", i, trace[i][F_OP][3:0]);
        end
      end
    end
  endtask

  initial begin : run
    int c;
    int errors_before;
    void'($urandom(32'h4b11984d));
    nRST        = 1'b0;
    issue_valid = 1'b0;
    op          = exec_pkg::OP_ADD;
    rs1_data    = '0;
    rs2_data    = '0;
    imm         = '0;
    pc          = '0;
    rd          = '0;
    cb_index    = '0;
    prediction  = 1'b0;
    errors      = 0;
    n_pass      = 0;
    n_fail      = 0;
    prev_redir  = 1'b0;
    load_trace();
    trace_loaded = 1'b1;
    if (n_rec == 0) begin
      $display("no usable records found in exec_trace.txt");
      $display("Simulation failed");
      $finish;
    end else begin
      repeat (3) @(posedge CLK);
      @(negedge CLK);
      errors_before = errors;
      if (wb_valid !== 1'b0) begin
        $display("wb_valid is not low during reset");
        errors++;
      end
      if (redirect_ff !== 1'b0) begin
        flag_mismatch(-1, "redirect_ff", redirect_ff, 32'h0);
      end
      if (errors == errors_before) begin
        n_pass++;
        $display("test reset: passed");
      end else begin
        n_fail++;
        $display("test reset: failed");
      end
      // fourth rising edge under reset
      @(posedge CLK);
      nRST <= 1'b1;
      for (c = 0; c < n_rec + `MUL_STAGES + 1; c++) begin
        @(posedge CLK);
        if (c < n_rec && trace[c][F_VALID][0]) begin
          drive_issue(c);
          rec_due[c] = c + int'(trace[c][F_OFF]);
          rec_fin[c] = (trace[c][F_OFF] == 0) ? c + 1 : rec_due[c];
          pend.push_back(c);
        end else begin
          drive_idle();
        end
        @(negedge CLK);
        scoreboard_cycle(c);
        close_records(c);
      end
      if (pend.size() != 0) begin
        $display("%0d results never came back", pend.size());
        errors++;
      end
      $display("%0d tests: %0d passed, %0d failed, %0d errors",
               n_pass + n_fail, n_pass, n_fail, errors);
      if (errors == 0 && n_fail == 0) begin
        $display("Simulation passed");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

  // run length follows from the number of trace records
  initial begin : watchdog
    wait (trace_loaded);
    #((n_rec + 10) * CLK_PERIOD);
    $display("timeout: run did not end within %0d cycles", n_rec + 10);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- exec_stage.f
+incdir+.
exec_pkg.sv
alu_unit.sv
branch_resolve.sv
mul_pipe.sv
wb_arbiter.sv
exec_stage.sv
tb_exec_stage.sv

//--- Bender.yml
package:
  name: exec_stage

sources:
  - include_dirs:
      - .
    files:
      - exec_pkg.sv
      - alu_unit.sv
      - branch_resolve.sv
      - mul_pipe.sv
      - wb_arbiter.sv
      - exec_stage.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_exec_stage.sv

//--- exec_trace.txt
# valid op rs1 rs2 imm pc rd idx pred | off exp_idx exp_rd exp_data exp_wen exp_exc redir redir_addr
# all fields hex, one cycle per line, off is cycles from issue to writeback
1 0 00000005 00000007 00000000 00001000 01 0 0 0 0 01 0000000c 1 0 0 00000000
1 0 ffffffff 00000002 00000000 00001004 02 1 0 0 1 02 00000001 1 0 0 00000000
1 1 00000003 00000005 00000000 00001008 03 2 0 0 2 03 fffffffe 1 0 0 00000000
1 2 f0f0f0f0 ff00ff00 00000000 0000100c 04 3 0 0 3 04 f000f000 1 0 0 00000000
1 3 f0f0f0f0 ff00ff00 00000000 00001010 05 4 0 0 4 05 fff0fff0 1 0 0 00000000
1 4 f0f0f0f0 ff00ff00 00000000 00001014 06 5 0 0 5 06 0ff00ff0 1 0 0 00000000
1 5 fffffff0 00000003 00000000 00001018 07 6 0 0 6 07 00000001 1 0 0 00000000
1 5 00000003 fffffff0 00000000 0000101c 08 7 0 0 7 08 00000000 1 0 0 00000000
1 6 00000010 00000010 00000020 00002000 09 0 1 0 0 09 00000000 0 0 0 00000000
1 7 00000001 00000002 00000040 00002010 0a 1 0 0 1 0a 00000000 0 0 1 00002050
1 8 00000005 fffffffb 00000100 00002020 0b 2 1 0 2 0b 00000000 0 0 1 00002024
1 9 00000000 00000000 00000200 00003000 01 3 0 0 3 01 00003004 1 0 1 00003200
1 a 00004001 00000000 00000010 00003100 0c 4 0 0 4 0c 00003104 1 0 1 00004010
1 6 00000000 00000000 00000006 00002000 0d 5 0 0 5 0d 00002000 0 2 0 00000000
1 9 00000000 00000000 00000102 00003000 0e 6 0 0 6 0e 00003000 0 2 0 00000000
1 a 00005000 00000000 00000003 00003200 0f 7 0 0 7 0f 00003200 0 2 0 00000000
1 d 00000000 00000000 00000000 00006000 10 0 0 0 0 10 00006000 0 1 0 00000000
0 0 00000000 00000000 00000000 00000000 00 0 0 0 0 00 00000000 0 0 0 00000000
1 b 00000003 00000007 00000000 00000000 11 1 0 3 1 11 00000015 1 0 0 00000000
1 b 00012345 00010000 00000000 00000000 12 2 0 3 2 12 23450000 1 0 0 00000000
1 b ffffffff ffffffff 00000000 00000000 13 3 0 3 3 13 00000001 1 0 0 00000000
0 0 00000000 00000000 00000000 00000000 00 0 0 0 0 00 00000000 0 0 0 00000000
0 0 00000000 00000000 00000000 00000000 00 0 0 0 0 00 00000000 0 0 0 00000000
0 0 00000000 00000000 00000000 00000000 00 0 0 0 0 00 00000000 0 0 0 00000000
1 b 0000ffff 0000ffff 00000000 00000000 14 4 0 3 4 14 fffe0001 1 0 0 00000000
1 4 12345678 ffffffff 00000000 00007000 15 5 0 0 5 15 edcba987 1 0 0 00000000
1 0 7fffffff 00000001 00000000 00007004 16 6 0 0 6 16 80000000 1 0 0 00000000
0 0 00000000 00000000 00000000 00000000 00 0 0 0 0 00 00000000 0 0 0 00000000
1 1 00000000 00000001 00000000 00007008 17 7 0 0 7 17 ffffffff 1 0 0 00000000
